// ==== vlog.f ====
+incdir+include
verilog/fetch_pkg.sv
verilog/fetch_pc_gen.sv
verilog/fetch_align.sv
verilog/rvc_expand.sv
verilog/fetch_frontend.sv
tests/fetch_frontend_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_frontend

sources:
  - include_dirs:
      - include
    files:
      - verilog/fetch_pkg.sv
      - verilog/fetch_pc_gen.sv
      - verilog/fetch_align.sv
      - verilog/rvc_expand.sv
      - verilog/fetch_frontend.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/fetch_frontend_tb.sv

// ==== tests/fetch_frontend_tb.sv ====
// Self-checking testbench; 4 KiB program image that wraps, reset_pc 0, redirects only while an item is held
`timescale 1ns/1ps

module fetch_frontend_tb;
	import fetch_pkg::*;
	`include "rvc_opcodes.svh"

	localparam logic [31:0] reset_pc = 32'd0;
	localparam int n_items = 2000; // Output items checked
	localparam int cycle_limit = 40 * n_items;

	logic clock;
	logic reset;
	logic [xlen-1:0] iaddr;
	fetch_word_u idata;
	logic ivalid;
	logic iready;
	logic redirect_valid;
	logic [xlen-1:0] redirect_pc;
	logic out_valid;
	expand_item_t out_item;
	logic consume;

	fetch_word_u mem [0:1023]; // Program image, 2048 half-words
	logic [31:0] bounds [0:2047]; // Start address of every instruction
	int nb;
	logic [31:0] rng;
	logic [31:0] model_pc; // Address of the next expected item
	bit jump_valid [0:n_items-1]; // Model jumps after this item
	logic [31:0] jump_target [0:n_items-1];
	expand_item_t held_item;
	logic holding; // out_item must not change at the next edge
	logic [31:0] last_pc;
	logic timed_out;
	int delay; // Memory wait cycles left
	int cycles;
	int items_done;
	int checks;
	int errors;
	int mark_checks;
	int mark_errors;
	int tests_run;
	int redirects;
	int n_compressed;
	int n_illegal;

	fetch_frontend #(
		.enable_compressed(1'b1),
		.reset_pc(reset_pc)
	) dut_i (
		.clock(clock),
		.reset(reset),
		.iaddr(iaddr),
		.idata(idata),
		.ivalid(ivalid),
		.iready(iready),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.out_valid(out_valid),
		.out_item(out_item),
		.consume(consume)
	);

	initial begin : clock_gen
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	function automatic logic [31:0] xorshift32();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// Random RVC word, mostly from the subset
	function automatic logic [15:0] random_rvc();
		logic [31:0] r;
		logic [4:0] op; // funct3 and quadrant
		logic [15:0] c;
		r = xorshift32();
		case (r[31:29])
			3'd0: op = {rvc_f3_lw, rvc_q0};
			3'd1: op = {rvc_f3_sw, rvc_q0};
			3'd2: op = {rvc_f3_addi, rvc_q1};
			3'd3: op = {rvc_f3_li, rvc_q1};
			3'd4: op = {rvc_f3_lui, rvc_q1};
			3'd5: op = {rvc_f3_j, rvc_q1};
			3'd6: op = {rvc_f3_cr, rvc_q2};
			default: op = {r[28:26], (r[1:0] == 2'b11) ? 2'b00 : r[1:0]}; // Mostly unsupported
		endcase
		c = {op[4:2], r[12:2], op[1:0]};
		if (op == {rvc_f3_cr, rvc_q2} && r[25]) c[6:2] = 5'd0; // Reach C.JR and reserved forms
		return c;
	endfunction

	task automatic put_half(input int h, input logic [15:0] v);
		if (h[0]) mem[h >> 1].half.hi = v;
		else mem[h >> 1].half.lo = v;
	endtask

	task automatic put_instr16(inout int h);
		bounds[nb] = h * 2;
		nb++;
		put_half(h, random_rvc());
		h++;
	endtask

	task automatic put_instr32(inout int h);
		logic [31:0] w;
		w = xorshift32() | 32'd3; // Low bits 11
		bounds[nb] = h * 2;
		nb++;
		put_half(h, w[15:0]);
		put_half(h + 1, w[31:16]);
		h += 2;
	endtask

	task automatic build_program();
		int h;
		h = 0;
		nb = 0;
		for (int k = 0; k < 8; k++) put_instr32(h); // Items 0 to 7, aligned
		put_instr16(h); // Items 8 and 9 share word 8
		put_instr16(h);
		put_instr16(h);
		put_instr32(h); // Item 11 at pc 38, joins words 9 and 10
		while (h < 2048) begin
			if (h == 2047 || xorshift32() % 2 == 0) put_instr16(h);
			else put_instr32(h);
		end
	endtask

	function automatic logic [15:0] half_at(input logic [31:0] pc);
		return pc[1] ? mem[pc[11:2]].half.hi : mem[pc[11:2]].half.lo; // Image wraps at 4 KiB
	endfunction

	// Spec expansion of the subset, result is {illegal, instr}
	function automatic logic [32:0] expand_rvc(input logic [15:0] c);
		logic [19:0] simm; // CI immediate, sign extended
		logic [11:0] uimm; // CL/CS word offset
		logic [20:0] joff; // CJ offset
		logic [4:0] rd;
		logic [4:0] rs2;
		logic [4:0] rdp; // rd' or rs2'
		logic [4:0] rs1p;
		simm = {{14{c[12]}}, c[12], c[6:2]};
		uimm = {5'b0, c[5], c[12:10], c[6], 2'b00};
		joff = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
		rd = c[11:7];
		rs2 = c[6:2];
		rdp = rvc_reg_base + {2'b00, c[4:2]};
		rs1p = rvc_reg_base + {2'b00, c[9:7]};
		case ({c[15:13], c[1:0]})
			{rvc_f3_lw, rvc_q0}: return {1'b0, uimm, rs1p, rv_f3_word, rdp, rv_op_load};
			{rvc_f3_sw, rvc_q0}: begin
				return {1'b0, uimm[11:5], rdp, rs1p, rv_f3_word, uimm[4:0], rv_op_store};
			end
			{rvc_f3_addi, rvc_q1}: return {1'b0, simm[11:0], rd, rv_f3_add, rd, rv_op_imm};
			{rvc_f3_li, rvc_q1}: return {1'b0, simm[11:0], 5'd0, rv_f3_add, rd, rv_op_imm};
			{rvc_f3_lui, rvc_q1}: begin
				if (rd != rvc_reg_sp && simm != 20'd0) return {1'b0, simm, rd, rv_op_lui};
			end
			{rvc_f3_j, rvc_q1}: begin
				return {1'b0, joff[20], joff[10:1], joff[11], joff[19:12], 5'd0, rv_op_jal};
			end
			{rvc_f3_cr, rvc_q2}: begin
				if (rs2 != 5'd0) begin // C.ADD adds rd, C.MV adds x0
					return {1'b0, 7'b0, rs2, c[12] ? rd : 5'd0, rv_f3_add, rd, rv_op_reg};
				end
				if (!c[12] && rd != 5'd0) return {1'b0, 12'd0, rd, rv_f3_add, 5'd0, rv_op_jalr};
			end
			default: ;
		endcase
		return {1'b1, 32'd0};
	endfunction

	function automatic expand_item_t model_item(input logic [31:0] pc);
		expand_item_t it;
		logic [15:0] lo_h;
		lo_h = half_at(pc);
		it.pc = pc;
		it.compressed = (lo_h[1:0] != 2'b11);
		if (it.compressed) {it.illegal, it.instr} = expand_rvc(lo_h);
		else {it.illegal, it.instr} = {1'b0, half_at(pc + 32'd2), lo_h};
		return it;
	endfunction

	task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		if (got !== want) begin
			$display("mismatch %s: got %08h expected %08h", name, got, want);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		$display("test %s: %0d checks, %0d errors", name, checks - mark_checks,
			errors - mark_errors);
		mark_checks = checks;
		mark_errors = errors;
		tests_run++;
	endtask

	// One item left the output register
	task automatic check_transfer();
		expand_item_t want;
		want = model_item(model_pc);
		check_field($sformatf("item %0d instr", items_done), out_item.instr, want.instr);
		check_field($sformatf("item %0d pc", items_done), out_item.pc, want.pc);
		check_field($sformatf("item %0d compressed", items_done), out_item.compressed,
			want.compressed);
		check_field($sformatf("item %0d illegal", items_done), out_item.illegal, want.illegal);
		if (items_done == 0) check_field("item 0 pc", out_item.pc, reset_pc);
		if (items_done == 8 || items_done == 9) begin
			check_field($sformatf("item %0d compressed", items_done), out_item.compressed, 1);
		end
		if (items_done == 9) check_field("item 9 pc step", out_item.pc - last_pc, 32'd2);
		if (items_done == 11) check_field("item 11 pc", out_item.pc, 32'd38); // Odd half-word
		n_compressed += out_item.compressed;
		n_illegal += out_item.illegal;
		model_pc = jump_valid[items_done] ? jump_target[items_done]
			: model_pc + (want.compressed ? 32'd2 : 32'd4);
		last_pc = out_item.pc;
		case (items_done)
			7: report_test("aligned_run");
			9: report_test("compressed_pair");
			11: report_test("unaligned_join");
			n_items - 1: report_test("random_stream");
			default: ;
		endcase
		items_done++;
	endtask

	initial begin : main
		reset = 1'b1;
		idata = '0;
		iready = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		consume = 1'b0;
		rng = 32'd8;
		model_pc = reset_pc;
		timed_out = 1'b0;
		build_program();
		for (int i = 0; i < 16; i++) begin
			@(posedge clock);
			if (i > 0) begin // Registers settle at the first edge
				check_field("ivalid in reset", ivalid, 0);
				check_field("out_valid in reset", out_valid, 0);
			end
		end
		reset <= 1'b0;
		@(posedge clock);
		check_field("ivalid after reset", ivalid, 0);
		check_field("out_valid after reset", out_valid, 0);
		report_test("reset");
		wait (items_done == n_items || timed_out);
		$display("tests %0d, checks %0d, errors %0d, redirects %0d, compressed %0d, illegal %0d",
			tests_run, checks, errors, redirects, n_compressed, n_illegal);
		if (errors == 0 && !timed_out) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// Memory responder, consume and redirect stimulus, output checks
	always @(posedge clock) begin : stimulus
		logic [31:0] target;
		if (reset) begin
			iready <= 1'b0;
			consume <= 1'b0;
			redirect_valid <= 1'b0;
			holding = 1'b0;
			delay = 0;
		end else begin
			cycles++;
			if (cycles > cycle_limit && !timed_out) begin
				$display("timeout: only %0d of %0d items came out in %0d cycles",
					items_done, n_items, cycles);
				timed_out = 1'b1;
			end
			if (holding && out_item !== held_item) begin
				$display("mismatch out_item while held: got %h expected %h", out_item, held_item);
				errors++;
			end
			if (out_valid && consume && items_done < n_items) check_transfer();
			holding = out_valid && !consume; // No transfer at this edge
			held_item = out_item;
			if (ivalid) check_field("iaddr low bits", iaddr[1:0], 0); // Word reads only
			if (iready) begin
				iready <= 1'b0; // One read per handshake
			end else if (ivalid) begin
				if (delay == 0) begin
					iready <= 1'b1;
					idata <= mem[iaddr[11:2]];
					delay = xorshift32() % 4;
				end else begin
					delay--;
				end
			end
			redirect_valid <= 1'b0;
			// Displayed item is items_done, the jump follows the next one
			if (holding && items_done >= 12 && items_done + 1 < n_items
				&& xorshift32() % 16 == 0) begin
				target = bounds[xorshift32() % nb];
				redirect_valid <= 1'b1;
				redirect_pc <= target;
				jump_valid[items_done + 1] = 1'b1; // A later pulse replaces it
				jump_target[items_done + 1] = target;
				redirects++;
			end
			consume <= (xorshift32() % 4 != 0); // Stall about one cycle in four
		end
	end

endmodule

// ==== verilog/fetch_frontend.sv ====
// Fetch front end top; one instruction at a time toward memory, redirects apply at the next take
`timescale 1ns/1ps

module fetch_frontend #(
	parameter bit enable_compressed = 1'b1,
	parameter logic [fetch_pkg::xlen-1:0] reset_pc = '0
) (
	input logic clock,
	input logic reset,
	output logic [fetch_pkg::xlen-1:0] iaddr,
	input fetch_pkg::fetch_word_u idata,
	output logic ivalid,
	input logic iready,
	input logic redirect_valid,
	input logic [fetch_pkg::xlen-1:0] redirect_pc,
	output logic out_valid,
	output fetch_pkg::expand_item_t out_item,
	input logic consume
);
	import fetch_pkg::*;

	logic [xlen-1:0] next_pc;
	logic next_pc_seq;
	logic take;
	logic fetch_valid;
	fetch_item_t fetch_item;

	fetch_pc_gen #(
		.reset_pc(reset_pc)
	) pc_gen_i (
		.clock(clock),
		.reset(reset),
		.take(take),
		.taken_compressed(fetch_item.compressed), // Step size of the item taken
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.next_pc(next_pc),
		.next_pc_seq(next_pc_seq)
	);

	fetch_align #(
		.enable_compressed(enable_compressed)
	) align_i (
		.clock(clock),
		.reset(reset),
		.next_pc(next_pc),
		.next_pc_seq(next_pc_seq),
		.iaddr(iaddr),
		.idata(idata),
		.ivalid(ivalid),
		.iready(iready),
		.fetch_valid(fetch_valid),
		.fetch_item(fetch_item),
		.take(take)
	);

	rvc_expand #(
		.enable_compressed(enable_compressed)
	) expand_i (
		.clock(clock),
		.reset(reset),
		.fetch_valid(fetch_valid),
		.fetch_item(fetch_item),
		.consume(consume),
		.take(take),
		.out_valid(out_valid),
		.out_item(out_item)
	);

endmodule

// ==== verilog/rvc_expand.sv ====
// RVC expansion stage; only C.ADDI, C.LI, C.LUI, C.MV, C.ADD, C.J, C.JR, C.LW, C.SW are expanded
`timescale 1ns/1ps

module rvc_expand #(
	parameter bit enable_compressed = 1'b1
) (
	input logic clock,
	input logic reset,
	input logic fetch_valid,
	input fetch_pkg::fetch_item_t fetch_item,
	input logic consume, // Downstream accepts out_item
	output logic take, // Decode-complete toward the fetch stage
	output logic out_valid,
	output fetch_pkg::expand_item_t out_item
);
	import fetch_pkg::*;
	`include "rvc_opcodes.svh"

	logic [hlen-1:0] ci; // Compressed instruction
	logic [1:0] quad;
	logic [2:0] funct3;
	logic [4:0] rd; // Full register fields, bits 11:7 and 6:2
	logic [4:0] rs2;
	logic [4:0] rs1p; // rd'/rs1' and rs2' mapped to x8..x15
	logic [4:0] rs2p;
	logic is_c;
	logic [xlen-1:0] exp_instr;
	logic exp_illegal;

	assign ci = fetch_item.instr[hlen-1:0];
	assign quad = ci[1:0];
	assign funct3 = ci[15:13];
	assign rd = ci[11:7];
	assign rs2 = ci[6:2];
	assign rs1p = rvc_reg_base + {2'b00, ci[9:7]};
	assign rs2p = rvc_reg_base + {2'b00, ci[4:2]};
	assign is_c = enable_compressed && fetch_item.compressed;

	always_comb begin
		exp_instr = '0; // Stays zero for unsupported forms
		exp_illegal = 1'b0;
		if (!is_c) begin
			exp_instr = fetch_item.instr; // 32-bit passes through
		end else begin
			exp_illegal = 1'b1; // Each supported form clears it
			case (quad)
				rvc_q0: begin
					case (funct3)
						rvc_f3_lw: begin // lw rd', uimm(rs1')
							exp_instr = {5'b0, ci[5], ci[12:10], ci[6], 2'b00, rs1p,
								rv_f3_word, rs2p, rv_op_load};
							exp_illegal = 1'b0;
						end
						rvc_f3_sw: begin // sw rs2', uimm(rs1')
							exp_instr = {5'b0, ci[5], ci[12], rs2p, rs1p, rv_f3_word,
								ci[11:10], ci[6], 2'b00, rv_op_store};
							exp_illegal = 1'b0;
						end
						default: ;
					endcase
				end
				rvc_q1: begin
					case (funct3)
						rvc_f3_addi: begin // addi rd, rd, imm
							exp_instr = {{6{ci[12]}}, ci[12], ci[6:2], rd, rv_f3_add, rd, rv_op_imm};
							exp_illegal = 1'b0;
						end
						rvc_f3_li: begin // addi rd, x0, imm
							exp_instr = {{6{ci[12]}}, ci[12], ci[6:2], 5'd0, rv_f3_add, rd,
								rv_op_imm};
							exp_illegal = 1'b0;
						end
						rvc_f3_lui: begin
							// Zero imm reserved
							if (rd != rvc_reg_sp && {ci[12], ci[6:2]} != 6'd0) begin
								exp_instr = {{14{ci[12]}}, ci[12], ci[6:2], rd, rv_op_lui};
								exp_illegal = 1'b0;
							end
						end
						rvc_f3_j: begin // jal x0, offset
							exp_instr = {ci[12], ci[8], ci[10:9], ci[6], ci[7], ci[2], ci[11],
								ci[5:3], ci[12], {8{ci[12]}}, 5'd0, rv_op_jal};
							exp_illegal = 1'b0;
						end
						default: ;
					endcase
				end
				rvc_q2: begin
					if (funct3 == rvc_f3_cr) begin
						if (!ci[12] && rs2 != 5'd0) begin // C.MV, add rd, x0, rs2
							exp_instr = {7'b0, rs2, 5'd0, rv_f3_add, rd, rv_op_reg};
							exp_illegal = 1'b0;
						end else if (!ci[12] && rd != 5'd0) begin // C.JR, jalr x0, 0(rs1)
							exp_instr = {12'b0, rd, rv_f3_add, 5'd0, rv_op_jalr};
							exp_illegal = 1'b0;
						end else if (ci[12] && rs2 != 5'd0) begin // C.ADD
							exp_instr = {7'b0, rs2, rd, rv_f3_add, rd, rv_op_reg};
							exp_illegal = 1'b0;
						end
					end
				end
				default: ;
			endcase
		end
	end

	// Register empty or draining this cycle
	assign take = fetch_valid && (!out_valid || consume);

	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (take) begin
			out_valid <= 1'b1;
		end else if (consume) begin
			out_valid <= 1'b0;
		end
	end

	// Held while waiting for consume
	always_ff @(posedge clock) begin
		if (take) begin
			out_item.instr <= exp_instr;
			out_item.pc <= fetch_item.pc;
			out_item.compressed <= is_c;
			out_item.illegal <= exp_illegal;
		end
	end

endmodule

// ==== verilog/fetch_align.sv ====
// Alignment fetch; every instruction is fetched fresh, memory must hold idata valid while iready is high
`timescale 1ns/1ps

module fetch_align #(
	parameter bit enable_compressed = 1'b1
) (
	input logic clock,
	input logic reset,

	// From the PC stage
	input logic [fetch_pkg::xlen-1:0] next_pc, // Held for the whole fetch
	input logic next_pc_seq, // Reserved for reuse of the leftover half-word

	// Instruction memory
	output logic [fetch_pkg::xlen-1:0] iaddr, // Always word aligned
	input fetch_pkg::fetch_word_u idata,
	output logic ivalid,
	input logic iready,

	// To the expansion stage
	output logic fetch_valid,
	output fetch_pkg::fetch_item_t fetch_item,
	input logic take
);
	import fetch_pkg::*;

	typedef enum logic [1:0] {
		st_fetch1, // First or only word
		st_fetch2, // Next word of an unaligned 32-bit instruction
		st_wait_take // Item offered, waiting for take
	} state_t;

	state_t state;
	logic ivalid_r;
	logic fetch_valid_r;
	logic [hlen-1:0] half_buf; // Low half of an unaligned 32-bit instruction
	logic [hlen-1:0] sel_half; // Half-word at the PC
	logic sel_c;
	logic read_done;

	assign sel_half = next_pc[1] ? idata.half.hi : idata.half.lo;
	assign sel_c = enable_compressed && is_rvc(sel_half[1:0]); // Forced false without RVC
	assign read_done = ivalid_r && iready;

	// Second read goes to the following word
	assign iaddr = (state == st_fetch2) ? {next_pc[xlen-1:2] + (xlen-2)'(1), 2'b00}
		: {next_pc[xlen-1:2], 2'b00};
	assign ivalid = ivalid_r;
	assign fetch_valid = fetch_valid_r; // Falls the cycle after take

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_fetch1;
			ivalid_r <= 1'b0;
			fetch_valid_r <= 1'b0;
		end else begin
			case (state)
				st_fetch1: begin
					if (read_done) begin
						case ({next_pc[1], sel_c})
							2'b00, 2'b01, 2'b11: begin // Whole instruction in this word
								ivalid_r <= 1'b0;
								fetch_valid_r <= 1'b1;
								state <= st_wait_take;
							end
							default: begin // Unaligned 32-bit, keep ivalid up
								state <= st_fetch2;
							end
						endcase
					end else begin
						ivalid_r <= 1'b1; // Start or hold the request
					end
				end
				st_fetch2: begin
					if (read_done) begin
						ivalid_r <= 1'b0;
						fetch_valid_r <= 1'b1;
						state <= st_wait_take;
					end
				end
				st_wait_take: begin
					if (take) begin
						fetch_valid_r <= 1'b0;
						state <= st_fetch1; // No reuse of the leftover half
					end
				end
				default: state <= st_fetch1;
			endcase
		end
	end

	// Item payload
	always_ff @(posedge clock) begin
		if (state == st_fetch1 && read_done) begin
			fetch_item.pc <= next_pc;
			fetch_item.compressed <= sel_c;
			half_buf <= idata.half.hi; // Only needed when the next read joins it
			if (sel_c) begin
				fetch_item.instr <= {{hlen{1'b0}}, sel_half};
			end else if (!next_pc[1]) begin
				fetch_item.instr <= idata.word;
			end
		end
		if (state == st_fetch2 && read_done) begin
			fetch_item.instr <= {idata.half.lo, half_buf}; // Join the two halves
		end
	end

endmodule

// ==== verilog/fetch_pc_gen.sv ====
// PC stage; redirect targets are taken as given with no alignment check, steps are 2 or 4 only
`timescale 1ns/1ps

module fetch_pc_gen #(
	parameter logic [fetch_pkg::xlen-1:0] reset_pc = '0
) (
	input logic clock,
	input logic reset,
	input logic take, // Current instruction accepted by the expansion stage
	input logic taken_compressed, // Size of the accepted instruction
	input logic redirect_valid, // One-cycle pulse
	input logic [fetch_pkg::xlen-1:0] redirect_pc,
	output logic [fetch_pkg::xlen-1:0] next_pc,
	output logic next_pc_seq
);
	import fetch_pkg::*;

	logic [xlen-1:0] pc;
	logic redirect_pending; // Target waits for the next take
	logic [xlen-1:0] redirect_target;
	logic jump_now;
	logic [xlen-1:0] jump_pc;
	logic [xlen-1:0] seq_pc;

	// A pulse in the take cycle itself counts as pending
	assign jump_now = redirect_pending || redirect_valid;
	assign jump_pc = redirect_valid ? redirect_pc : redirect_target; // Newest pulse wins
	assign seq_pc = pc + (taken_compressed ? xlen'(2) : xlen'(4));

	assign next_pc = pc; // Stable until the cycle after take

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= reset_pc;
			redirect_pending <= 1'b0;
			next_pc_seq <= 1'b0; // Nothing precedes the first fetch
		end else if (take) begin
			if (jump_now) begin
				pc <= jump_pc;
			end else begin
				pc <= seq_pc;
			end
			next_pc_seq <= !jump_now; // Low for the one instruction at the target
			redirect_pending <= 1'b0;
		end else if (redirect_valid) begin
			redirect_pending <= 1'b1;
		end
	end

	// Target only matters while pending
	always_ff @(posedge clock) begin
		if (redirect_valid) begin
			redirect_target <= redirect_pc;
		end
	end

endmodule

// ==== verilog/fetch_pkg.sv ====
// Shared fetch types for an RV32 front end; xlen is fixed at 32 and RVC instructions are 16 bits
package fetch_pkg;

	localparam int xlen = 32; // Instruction and address width
	localparam int hlen = xlen / 2; // Half-word width, the RVC granule

	// Two half-words of one memory word
	typedef struct packed {
		logic [hlen-1:0] hi; // Bits 31:16, the half-word at offset 2
		logic [hlen-1:0] lo; // Bits 15:0, the half-word at offset 0
	} half_pair_t;

	// Word read from instruction memory
	typedef union packed {
		logic [xlen-1:0] word; // Whole aligned 32-bit instruction
		half_pair_t half; // Split view for RVC and unaligned joins
	} fetch_word_u;

	// Fetch stage to expansion stage
	typedef struct packed {
		logic [xlen-1:0] instr; // Upper half zero when compressed
		logic compressed; // Instruction is 16 bits
		logic [xlen-1:0] pc; // Half-word aligned address
	} fetch_item_t;

	// Expansion stage output
	typedef struct packed {
		logic [xlen-1:0] instr; // Always the 32-bit form
		logic [xlen-1:0] pc;
		logic compressed; // Came from a 16-bit encoding
		logic illegal; // Unsupported RVC encoding, instr is zero
	} expand_item_t;

	// Low two bits of 11 mark a 32-bit instruction, anything else is RVC
	function automatic logic is_rvc(input logic [1:0] low_bits);
		return low_bits != 2'b11;
	endfunction

endpackage

// ==== include/rvc_opcodes.svh ====
// RVC subset constants as localparams; include inside a module body, each includer gets its own copy

// Quadrant, bits 1:0 of a compressed instruction
localparam logic [1:0] rvc_q0 = 2'b00; // Loads and stores
localparam logic [1:0] rvc_q1 = 2'b01; // Immediates and jumps
localparam logic [1:0] rvc_q2 = 2'b10; // Register moves and jump register

// funct3 in bits 15:13, quadrant 0
localparam logic [2:0] rvc_f3_lw = 3'b010; // C.LW
localparam logic [2:0] rvc_f3_sw = 3'b110; // C.SW

// funct3, quadrant 1
localparam logic [2:0] rvc_f3_addi = 3'b000; // C.ADDI and C.NOP
localparam logic [2:0] rvc_f3_li = 3'b010; // C.LI
localparam logic [2:0] rvc_f3_lui = 3'b011; // C.LUI, rd of 2 is C.ADDI16SP
localparam logic [2:0] rvc_f3_j = 3'b101; // C.J

// funct3, quadrant 2
localparam logic [2:0] rvc_f3_cr = 3'b100; // C.MV, C.ADD, C.JR by bit 12 and rs2

// Register fields
localparam logic [4:0] rvc_reg_base = 5'd8; // rd' and rs' map to x8..x15
localparam logic [4:0] rvc_reg_sp = 5'd2; // Stack pointer, excluded from C.LUI

// 32-bit major opcodes produced by the expansion
localparam logic [6:0] rv_op_imm = 7'b0010011;
localparam logic [6:0] rv_op_lui = 7'b0110111;
localparam logic [6:0] rv_op_reg = 7'b0110011;
localparam logic [6:0] rv_op_jal = 7'b1101111;
localparam logic [6:0] rv_op_jalr = 7'b1100111;
localparam logic [6:0] rv_op_load = 7'b0000011;
localparam logic [6:0] rv_op_store = 7'b0100011;

// 32-bit funct3 values
localparam logic [2:0] rv_f3_add = 3'b000; // ADDI, ADD, JALR
localparam logic [2:0] rv_f3_word = 3'b010; // LW, SW
